// File: list.f
+incdir+dv
verilog/exec_pkg.sv
verilog/exec_op_decoder.sv
verilog/exec_alu.sv
verilog/exec_branch_unit.sv
verilog/exec_handshake.sv
verilog/exec_stage.sv
dv/tb_exec_stage.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - verilog/exec_pkg.sv
  - verilog/exec_op_decoder.sv
  - verilog/exec_alu.sv
  - verilog/exec_branch_unit.sv
  - verilog/exec_handshake.sv
  - verilog/exec_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_exec_stage.sv

// File: dv/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// expected stage outputs for one operation.
typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    logic            taken;
    logic            jump;
    logic            write_rd;
    logic            illegal;
} expect_t;

function automatic expect_t model_exec(
    input logic [ONEHOT_W-1:0] vec,
    input logic [XLEN-1:0]     a,
    input logic [XLEN-1:0]     b,
    input logic [XLEN-1:0]     imm,
    input logic [XLEN-1:0]     pc
);
    expect_t e;
    int      idx;
    e = '0;
    idx = 0;
    if ($countones(vec) != 1) begin
        e.illegal = 1'b1;
        return e;
    end
    for (int i = 0; i < ONEHOT_W; i++) begin
        if (vec[i]) begin
            idx = i;
        end
    end
    e.write_rd = 1'b1;
    case (idx)
        INST_ADD_BIT:   e.result = a + b;
        INST_SUB_BIT:   e.result = a - b;
        INST_XOR_BIT:   e.result = a ^ b;
        INST_OR_BIT:    e.result = a | b;
        INST_AND_BIT:   e.result = a & b;
        INST_SLL_BIT:   e.result = a << b[4:0];
        INST_SRL_BIT:   e.result = a >> b[4:0];
        INST_SRA_BIT:   e.result = $signed(a) >>> b[4:0];
        INST_SLT_BIT:   e.result = ($signed(a) < $signed(b)) ? 1 : 0;
        INST_SLTU_BIT:  e.result = (a < b) ? 1 : 0;
        INST_ADDI_BIT:  e.result = a + imm;
        INST_XORI_BIT:  e.result = a ^ imm;
        INST_ORI_BIT:   e.result = a | imm;
        INST_ANDI_BIT:  e.result = a & imm;
        INST_SLLI_BIT:  e.result = a << imm[4:0];
        INST_SRLI_BIT:  e.result = a >> imm[4:0];
        INST_SRAI_BIT:  e.result = $signed(a) >>> imm[4:0];
        INST_SLTI_BIT:  e.result = ($signed(a) < $signed(imm)) ? 1 : 0;
        INST_SLTIU_BIT: e.result = (a < imm) ? 1 : 0;
        INST_LB_BIT, INST_LH_BIT, INST_LW_BIT, INST_LBU_BIT, INST_LHU_BIT: e.result = a + imm;
        INST_SB_BIT, INST_SH_BIT, INST_SW_BIT: begin
            e.result = a + imm;
            e.write_rd = 1'b0;
        end
        INST_BEQ_BIT:   e.taken = (a == b);
        INST_BNE_BIT:   e.taken = (a != b);
        INST_BLT_BIT:   e.taken = ($signed(a) < $signed(b));
        INST_BGE_BIT:   e.taken = ($signed(a) >= $signed(b));
        INST_BLTU_BIT:  e.taken = (a < b);
        INST_BGEU_BIT:  e.taken = (a >= b);
        INST_JAL_BIT: begin
            e.result = pc + 4;
            e.target = pc + imm;
            e.jump = 1'b1;
        end
        INST_JALR_BIT: begin
            e.result = pc + 4;
            e.target = a + imm;
            e.jump = 1'b1;
        end
        INST_LUI_BIT:   e.result = imm;
        INST_AUIPC_BIT: e.result = pc + imm;
        default: begin
            e.write_rd = 1'b0;
            e.illegal = 1'b1;
        end
    endcase
    // branches carry no result and write no register.
    if (idx >= INST_BEQ_BIT && idx <= INST_BGEU_BIT) begin
        e.target = pc + imm;
        e.write_rd = 1'b0;
    end
    return e;
endfunction

`endif

// File: dv/tb_exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exec_stage
    import exec_pkg::*;
();

    localparam int XLEN            = 32;
    localparam int NUM_OPS         = 2000;
    localparam int RESET_CYCLES    = 16;
    localparam int MAX_GAP         = 5;
    localparam int ACK_LIMIT       = 20;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_OPS * (2 * MAX_GAP + 4);
    localparam logic [31:0] SEED   = 32'h158f_4aac;

    `include "exec_model.svh"

    logic                clk;
    logic                arst_n;
    logic                req;
    logic [ONEHOT_W-1:0] inst_onehot;
    logic [XLEN-1:0]     operand1;
    logic [XLEN-1:0]     operand2;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     pc;
    logic                ack;
    logic [XLEN-1:0]     result;
    logic [XLEN-1:0]     target;
    logic                branch_taken;
    logic                jump;
    logic                write_rd;
    logic                illegal;
    int                  value_errors = 0;
    int                  protocol_errors = 0;

    exec_stage #(
        .XLEN (XLEN)
    ) uut (
        .i_clk          (clk),
        .arst_n_i       (arst_n),
        .req_i          (req),
        .inst_onehot_i  (inst_onehot),
        .operand1_i     (operand1),
        .operand2_i     (operand2),
        .imm_i          (imm),
        .pc_i           (pc),
        .ack_o          (ack),
        .result_o       (result),
        .target_o       (target),
        .branch_taken_o (branch_taken),
        .jump_o         (jump),
        .write_rd_o     (write_rd),
        .illegal_o      (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // most vectors are kept operations and about one in ten is illegal.
    function automatic logic [ONEHOT_W-1:0] random_vector();
        logic [ONEHOT_W-1:0] v;
        int                  a;
        int                  b;
        v = '0;
        if ($urandom_range(0, 9) != 0) begin
            v[$urandom_range(INST_ADD_BIT, INST_AUIPC_BIT)] = 1'b1;
        end else begin
            case ($urandom_range(0, 2))
                0: v = '0;
                1: begin
                    a = $urandom_range(0, ONEHOT_W - 1);
                    b = (a + 1 + $urandom_range(0, ONEHOT_W - 2)) % ONEHOT_W;
                    v[a] = 1'b1;
                    v[b] = 1'b1;
                end
                default: begin
                    a = $urandom_range(0, 10);
                    v[(a == 0) ? INST_UNKNOWN_BIT : INST_ECALL_BIT + a - 1] = 1'b1;
                end
            endcase
        end
        return v;
    endfunction

    // small sign-extended values hit the compare and shift corners more often.
    function automatic logic [XLEN-1:0] random_word();
        logic [XLEN-1:0] w;
        w = $urandom;
        if ($urandom_range(0, 1) == 0) begin
            w = {{(XLEN - 12){w[11]}}, w[11:0]};
        end
        return w;
    endfunction

    function automatic string test_name(input logic [ONEHOT_W-1:0] vec, input int n);
        int    idx;
        string kind;
        idx = 0;
        for (int i = 0; i < ONEHOT_W; i++) begin
            if (vec[i]) begin
                idx = i;
            end
        end
        if ($countones(vec) != 1 || idx < INST_ADD_BIT || idx > INST_AUIPC_BIT) kind = "illegal";
        else if (idx <= INST_SLTU_BIT) kind = "reg_alu";
        else if (idx <= INST_SLTIU_BIT) kind = "imm_alu";
        else if (idx <= INST_LHU_BIT) kind = "load";
        else if (idx <= INST_SW_BIT) kind = "store";
        else if (idx <= INST_BGEU_BIT) kind = "branch";
        else if (idx <= INST_JALR_BIT) kind = "jump";
        else kind = "upper";
        return $sformatf("%s op %0d", kind, n);
    endfunction

    task automatic load_inputs();
        inst_onehot = random_vector();
        operand1 = random_word();
        operand2 = ($urandom_range(0, 7) == 0) ? operand1 : random_word();
        imm = random_word();
        pc = random_word();
        pc[1:0] = 2'b00;
    endtask

    task automatic protocol_error(input string msg);
        protocol_errors++;
        $display("protocol error: %s", msg);
    endtask

    task automatic check_field(input string name, input string field,
                               input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_outputs(input expect_t e, input string name);
        check_field(name, "result", e.result, result);
        check_field(name, "target", e.target, target);
        check_field(name, "branch_taken", e.taken, branch_taken);
        check_field(name, "jump", e.jump, jump);
        check_field(name, "write_rd", e.write_rd, write_rd);
        check_field(name, "illegal", e.illegal, illegal);
    endtask

    // ack must follow req after exactly one rising edge.
    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack !== level && cycles < ACK_LIMIT);
        assert (ack === level) else
            protocol_error($sformatf("ack did not go to %0b within %0d cycles", level, ACK_LIMIT));
        assert (cycles == 1) else
            protocol_error($sformatf("ack went to %0b after %0d cycles instead of one",
                                     level, cycles));
    endtask

    initial begin
        expect_t prev;
        expect_t cur;
        string   name;
        int      gap;
        void'($urandom(SEED));
        arst_n = 1'b0;
        req = 1'b0;
        inst_onehot = '0;
        operand1 = '0;
        operand2 = '0;
        imm = '0;
        pc = '0;
        prev = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (ack === 1'b0) else protocol_error("ack is high after reset");
        check_outputs(prev, "reset");
        for (int n = 0; n < NUM_OPS; n++) begin
            // inputs may change freely while req is low and the outputs must hold.
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) begin
                @(negedge clk);
                load_inputs();
                assert (ack === 1'b0) else protocol_error("ack rose without a request");
                check_outputs(prev, "idle hold");
            end
            load_inputs();
            cur = model_exec(inst_onehot, operand1, operand2, imm, pc);
            name = test_name(inst_onehot, n);
            req = 1'b1;
            wait_ack(1'b1);
            check_outputs(cur, name);
            gap = $urandom_range(0, MAX_GAP);
            repeat (gap) begin
                @(negedge clk);
                assert (ack === 1'b1) else protocol_error("ack fell while req was still high");
                check_outputs(cur, {name, " hold"});
            end
            req = 1'b0;
            wait_ack(1'b0);
            check_outputs(cur, {name, " release"});
            prev = cur;
        end
        @(negedge clk);
        $display("summary: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage
    import exec_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire                 i_clk,
    input  wire                 arst_n_i,
    input  wire                 req_i,
    input  wire [ONEHOT_W-1:0]  inst_onehot_i,
    input  wire [XLEN-1:0]      operand1_i,
    input  wire [XLEN-1:0]      operand2_i,
    input  wire [XLEN-1:0]      imm_i,
    input  wire [XLEN-1:0]      pc_i,
    output logic                ack_o,
    output logic [XLEN-1:0]     result_o,
    output logic [XLEN-1:0]     target_o,
    output logic                branch_taken_o,
    output logic                jump_o,
    output logic                write_rd_o,
    output logic                illegal_o
);

    ex_op_e          op;
    logic            write_rd;
    logic            illegal;
    logic [XLEN-1:0] alu_result;
    logic            taken;
    logic            jump;
    logic [XLEN-1:0] target;

    exec_op_decoder u_decoder (
        .inst_onehot_i (inst_onehot_i),
        .op_o          (op),
        .write_rd_o    (write_rd),
        .illegal_o     (illegal)
    );

    exec_alu #(
        .XLEN (XLEN)
    ) u_alu (
        .op_i       (op),
        .operand1_i (operand1_i),
        .operand2_i (operand2_i),
        .imm_i      (imm_i),
        .pc_i       (pc_i),
        .result_o   (alu_result)
    );

    exec_branch_unit #(
        .XLEN (XLEN)
    ) u_branch (
        .op_i       (op),
        .operand1_i (operand1_i),
        .operand2_i (operand2_i),
        .imm_i      (imm_i),
        .pc_i       (pc_i),
        .taken_o    (taken),
        .jump_o     (jump),
        .target_o   (target)
    );

    exec_handshake #(
        .XLEN (XLEN)
    ) u_handshake (
        .i_clk          (i_clk),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .result_i       (alu_result),
        .target_i       (target),
        .taken_i        (taken),
        .jump_i         (jump),
        .write_rd_i     (write_rd),
        .illegal_i      (illegal),
        .ack_o          (ack_o),
        .result_o       (result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .write_rd_o     (write_rd_o),
        .illegal_o      (illegal_o)
    );

endmodule

`default_nettype wire

// File: verilog/exec_handshake.sv
`timescale 1ns/10ps
`default_nettype none

module exec_handshake #(
    parameter int XLEN = 32
) (
    input  wire             i_clk,
    input  wire             arst_n_i,
    input  wire             req_i,
    input  wire [XLEN-1:0]  result_i,
    input  wire [XLEN-1:0]  target_i,
    input  wire             taken_i,
    input  wire             jump_i,
    input  wire             write_rd_i,
    input  wire             illegal_i,
    output logic            ack_o,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] target_o,
    output logic            branch_taken_o,
    output logic            jump_o,
    output logic            write_rd_o,
    output logic            illegal_o
);

    logic capture;
    logic release_ack;

    // a new request is only taken once the previous ack has dropped.
    assign capture     = req_i && !ack_o;
    assign release_ack = !req_i && ack_o;

    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else if (capture) begin
            ack_o <= 1'b1;
        end else if (release_ack) begin
            ack_o <= 1'b0;
        end
    end

    // outputs hold from the rise of ack until the next request is captured.
    always_ff @(posedge i_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_o       <= '0;
            target_o       <= '0;
            branch_taken_o <= 1'b0;
            jump_o         <= 1'b0;
            write_rd_o     <= 1'b0;
            illegal_o      <= 1'b0;
        end else if (capture) begin
            result_o       <= result_i;
            target_o       <= target_i;
            branch_taken_o <= taken_i;
            jump_o         <= jump_i;
            write_rd_o     <= write_rd_i;
            illegal_o      <= illegal_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_branch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_branch_unit
    import exec_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire ex_op_e          op_i,
    input  wire [XLEN-1:0]       operand1_i,
    input  wire [XLEN-1:0]       operand2_i,
    input  wire [XLEN-1:0]       imm_i,
    input  wire [XLEN-1:0]       pc_i,
    output logic                 taken_o,
    output logic                 jump_o,
    output logic [XLEN-1:0]      target_o
);

    logic eq;
    logic lt_signed;
    logic lt_unsigned;

    assign eq          = operand1_i == operand2_i;
    assign lt_signed   = $signed(operand1_i) < $signed(operand2_i);
    assign lt_unsigned = operand1_i < operand2_i;

    always_comb begin
        case (op_i)
            EX_OP_BEQ:  taken_o = eq;
            EX_OP_BNE:  taken_o = !eq;
            EX_OP_BLT:  taken_o = lt_signed;
            EX_OP_BGE:  taken_o = !lt_signed;
            EX_OP_BLTU: taken_o = lt_unsigned;
            EX_OP_BGEU: taken_o = !lt_unsigned;
            default:    taken_o = 1'b0;
        endcase
    end

    assign jump_o = (op_i == EX_OP_JAL) || (op_i == EX_OP_JALR);

    // branches and JAL are pc relative, JALR is register relative.
    always_comb begin
        if ((op_i inside {[EX_OP_BEQ:EX_OP_BGEU]}) || (op_i == EX_OP_JAL)) begin
            target_o = pc_i + imm_i;
        end else if (op_i == EX_OP_JALR) begin
            target_o = operand1_i + imm_i;
        end else begin
            target_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exec_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exec_alu
    import exec_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire ex_op_e          op_i,
    input  wire [XLEN-1:0]       operand1_i,
    input  wire [XLEN-1:0]       operand2_i,
    input  wire [XLEN-1:0]       imm_i,
    input  wire [XLEN-1:0]       pc_i,
    output logic [XLEN-1:0]      result_o
);

    // five bits of shift amount for 32 bits, six for 64.
    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0]    src2;
    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // immediate forms take the second source from the immediate.
    assign src2 = (op_i inside {[EX_OP_ADDI:EX_OP_SLTIU]}) ? imm_i : operand2_i;

    assign shamt       = src2[SHAMT_W-1:0];
    assign lt_signed   = $signed(operand1_i) < $signed(src2);
    assign lt_unsigned = operand1_i < src2;

    always_comb begin
        case (op_i)
            EX_OP_ADD, EX_OP_ADDI: result_o = operand1_i + src2;
            EX_OP_SUB:             result_o = operand1_i - src2;
            EX_OP_XOR, EX_OP_XORI: result_o = operand1_i ^ src2;
            EX_OP_OR, EX_OP_ORI:   result_o = operand1_i | src2;
            EX_OP_AND, EX_OP_ANDI: result_o = operand1_i & src2;
            EX_OP_SLL, EX_OP_SLLI: result_o = operand1_i << shamt;
            EX_OP_SRL, EX_OP_SRLI: result_o = operand1_i >> shamt;
            EX_OP_SRA, EX_OP_SRAI: result_o = $signed(operand1_i) >>> shamt;
            EX_OP_SLT, EX_OP_SLTI: result_o = {{(XLEN-1){1'b0}}, lt_signed};
            EX_OP_SLTU, EX_OP_SLTIU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            // effective address for every load and store.
            EX_OP_LB, EX_OP_LH, EX_OP_LW, EX_OP_LBU, EX_OP_LHU,
            EX_OP_SB, EX_OP_SH, EX_OP_SW: begin
                result_o = operand1_i + imm_i;
            end
            // link address of the following instruction.
            EX_OP_JAL, EX_OP_JALR: result_o = pc_i + XLEN'(4);
            EX_OP_LUI:             result_o = imm_i;
            EX_OP_AUIPC:           result_o = pc_i + imm_i;
            default:               result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/exec_op_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module exec_op_decoder
    import exec_pkg::*;
(
    input  wire [ONEHOT_W-1:0] inst_onehot_i,
    output ex_op_e             op_o,
    output logic               write_rd_o,
    output logic               illegal_o
);

    localparam int IDX_W = $clog2(ONEHOT_W);

    logic [IDX_W-1:0] hit_idx;
    logic             any_bit;
    logic             single_bit;
    logic             kept_bit;

    // position of the set bit. only meaningful when exactly one bit is set.
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < ONEHOT_W; i++) begin
            if (inst_onehot_i[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    // clearing the lowest set bit leaves nothing for a true one-hot vector.
    assign any_bit    = |inst_onehot_i;
    assign single_bit = any_bit &&
                        ((inst_onehot_i & (inst_onehot_i - 1'b1)) == '0);

    // the unknown bit and the system and CSR bits fall outside this range.
    assign kept_bit = (int'(hit_idx) >= INST_ADD_BIT) &&
                      (int'(hit_idx) <= INST_AUIPC_BIT);

    always_comb begin
        if (single_bit && kept_bit) begin
            op_o      = ex_op_e'(hit_idx);
            illegal_o = 1'b0;
        end else begin
            op_o      = EX_OP_NONE;
            illegal_o = 1'b1;
        end
    end

    // stores and branches leave the register file alone.
    always_comb begin
        case (op_o)
            EX_OP_ADD, EX_OP_SUB, EX_OP_XOR, EX_OP_OR, EX_OP_AND,
            EX_OP_SLL, EX_OP_SRL, EX_OP_SRA, EX_OP_SLT, EX_OP_SLTU: begin
                write_rd_o = 1'b1;
            end
            EX_OP_ADDI, EX_OP_XORI, EX_OP_ORI, EX_OP_ANDI, EX_OP_SLLI,
            EX_OP_SRLI, EX_OP_SRAI, EX_OP_SLTI, EX_OP_SLTIU: begin
                write_rd_o = 1'b1;
            end
            EX_OP_LB, EX_OP_LH, EX_OP_LW, EX_OP_LBU, EX_OP_LHU: begin
                write_rd_o = 1'b1;
            end
            EX_OP_JAL, EX_OP_JALR, EX_OP_LUI, EX_OP_AUIPC: begin
                write_rd_o = 1'b1;
            end
            default: begin
                write_rd_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // width of the one-hot instruction vector from decode.
    localparam int ONEHOT_W = 64;

    // one-hot bit positions. bit 0 flags an instruction decode could not identify.
    localparam int INST_UNKNOWN_BIT = 0;
    localparam int INST_ADD_BIT     = 1;
    localparam int INST_SUB_BIT     = 2;
    localparam int INST_XOR_BIT     = 3;
    localparam int INST_OR_BIT      = 4;
    localparam int INST_AND_BIT     = 5;
    localparam int INST_SLL_BIT     = 6;
    localparam int INST_SRL_BIT     = 7;
    localparam int INST_SRA_BIT     = 8;
    localparam int INST_SLT_BIT     = 9;
    localparam int INST_SLTU_BIT    = 10;
    localparam int INST_ADDI_BIT    = 11;
    localparam int INST_XORI_BIT    = 12;
    localparam int INST_ORI_BIT     = 13;
    localparam int INST_ANDI_BIT    = 14;
    localparam int INST_SLLI_BIT    = 15;
    localparam int INST_SRLI_BIT    = 16;
    localparam int INST_SRAI_BIT    = 17;
    localparam int INST_SLTI_BIT    = 18;
    localparam int INST_SLTIU_BIT   = 19;
    localparam int INST_LB_BIT      = 20;
    localparam int INST_LH_BIT      = 21;
    localparam int INST_LW_BIT      = 22;
    localparam int INST_LBU_BIT     = 23;
    localparam int INST_LHU_BIT     = 24;
    localparam int INST_SB_BIT      = 25;
    localparam int INST_SH_BIT      = 26;
    localparam int INST_SW_BIT      = 27;
    localparam int INST_BEQ_BIT     = 28;
    localparam int INST_BNE_BIT     = 29;
    localparam int INST_BLT_BIT     = 30;
    localparam int INST_BGE_BIT     = 31;
    localparam int INST_BLTU_BIT    = 32;
    localparam int INST_BGEU_BIT    = 33;
    localparam int INST_JAL_BIT     = 34;
    localparam int INST_JALR_BIT    = 35;
    localparam int INST_LUI_BIT     = 36;
    localparam int INST_AUIPC_BIT   = 37;
    localparam int INST_ECALL_BIT   = 38;
    localparam int INST_EBREAK_BIT  = 39;
    localparam int INST_FENCE_BIT   = 40;
    localparam int INST_FENCEI_BIT  = 41;
    localparam int INST_CSRRW_BIT   = 42;
    localparam int INST_CSRRS_BIT   = 43;
    localparam int INST_CSRRC_BIT   = 44;
    localparam int INST_CSRRWI_BIT  = 45;
    localparam int INST_CSRRSI_BIT  = 46;
    localparam int INST_CSRRCI_BIT  = 47;

    // operation codes follow the bit order above, so a kept bit position
    // is also the value of its operation.
    typedef enum logic [5:0] {
        EX_OP_NONE,
        EX_OP_ADD, EX_OP_SUB, EX_OP_XOR, EX_OP_OR, EX_OP_AND,
        EX_OP_SLL, EX_OP_SRL, EX_OP_SRA, EX_OP_SLT, EX_OP_SLTU,
        EX_OP_ADDI, EX_OP_XORI, EX_OP_ORI, EX_OP_ANDI, EX_OP_SLLI,
        EX_OP_SRLI, EX_OP_SRAI, EX_OP_SLTI, EX_OP_SLTIU,
        EX_OP_LB, EX_OP_LH, EX_OP_LW, EX_OP_LBU, EX_OP_LHU,
        EX_OP_SB, EX_OP_SH, EX_OP_SW,
        EX_OP_BEQ, EX_OP_BNE, EX_OP_BLT, EX_OP_BGE, EX_OP_BLTU, EX_OP_BGEU,
        EX_OP_JAL, EX_OP_JALR, EX_OP_LUI, EX_OP_AUIPC
    } ex_op_e;

endpackage

`default_nettype wire
